//--- hdl/switch_pkg.sv
package switch_pkg;

    // default sizes, the top level overrides them through its parameters
    localparam int DATA_W     = 16;
    localparam int PAGE_WORDS = 8;
    localparam int NUM_PAGES  = 64;
    localparam int N_PORTS    = 4;
    localparam int MAX_LEN    = 32;

    typedef logic [$clog2(NUM_PAGES)-1:0]  page_t;
    typedef logic [$clog2(N_PORTS)-1:0]    port_t;
    typedef logic [$clog2(PAGE_WORDS)-1:0] offset_t;

    // one stored word, eop marks the packet end inside the memory
    typedef struct packed {
        logic              eop;
        logic [DATA_W-1:0] data;
    } buf_word_t;

    typedef struct packed {
        logic      en;
        page_t     page;
        offset_t   offset;
        buf_word_t word;
    } wr_req_t;

    typedef struct packed {
        logic  en;
        page_t from_page;
        page_t to_page;
    } link_req_t;

    typedef struct packed {
        logic  en;
        port_t dest;
        page_t head_page;
        page_t tail_page;
    } enq_req_t;

    typedef struct packed {
        logic    en;
        page_t   page;
        offset_t offset;
    } rd_req_t;

    // header means the packet is still on its first page
    typedef enum logic [1:0] {
        in_idle,
        in_header,
        in_body
    } ingress_state_e;

    typedef enum logic [1:0] {
        eg_pick,
        eg_fetch,
        eg_present,
        eg_advance
    } egress_state_e;

endpackage

//--- hdl/packet_ingress.sv
`timescale 1ns/10ps

module packet_ingress #(
    parameter int DATA_W     = switch_pkg::DATA_W,
    parameter int PAGE_WORDS = switch_pkg::PAGE_WORDS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  logic [DATA_W-1:0]     wr_data,
    input  switch_pkg::page_t     free_page,
    input  logic                  full,
    output switch_pkg::wr_req_t   wr_req,
    output switch_pkg::link_req_t link_req,
    output switch_pkg::enq_req_t  enq_req,
    output logic                  alloc
);

    switch_pkg::ingress_state_e state;
    switch_pkg::offset_t        offset;
    logic                       take;
    logic                       page_last;

    // word taken last cycle, written to memory this cycle
    logic                       acc_vld;
    logic                       acc_sop;
    logic                       acc_new_page;
    logic                       acc_link;
    switch_pkg::offset_t        acc_offset;
    switch_pkg::buf_word_t      acc_word;

    switch_pkg::page_t          cur_page;
    switch_pkg::page_t          pkt_head;
    switch_pkg::port_t          pkt_dest;
    switch_pkg::page_t          page_now;
    switch_pkg::port_t          dest_now;

    // a new packet is refused while full, its later words fall away in idle
    assign take      = wr_vld && (state != switch_pkg::in_idle || (wr_sop && !full));
    assign page_last = offset == switch_pkg::offset_t'(PAGE_WORDS - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= switch_pkg::in_idle;
            offset  <= '0;
            acc_vld <= 1'b0;
        end else begin
            acc_vld <= take;
            if (take) begin
                if (wr_eop || page_last) begin
                    offset <= '0;
                end else begin
                    offset <= offset + 1'b1;
                end
                case (state)
                    switch_pkg::in_idle: begin
                        if (!wr_eop) begin
                            state <= switch_pkg::in_header;
                        end
                    end
                    switch_pkg::in_header: begin
                        if (wr_eop) begin
                            state <= switch_pkg::in_idle;
                        end else if (page_last) begin
                            state <= switch_pkg::in_body;
                        end
                    end
                    switch_pkg::in_body: begin
                        if (wr_eop) begin
                            state <= switch_pkg::in_idle;
                        end
                    end
                    default: state <= switch_pkg::in_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_sop       <= state == switch_pkg::in_idle;
            acc_new_page  <= offset == '0;
            // every page after the first hangs off the one before
            acc_link      <= state == switch_pkg::in_body && offset == '0;
            acc_offset    <= offset;
            acc_word.eop  <= wr_eop;
            acc_word.data <= wr_data;
        end
        if (acc_vld) begin
            cur_page <= page_now;
            if (acc_sop) begin
                pkt_head <= page_now;
                pkt_dest <= dest_now;
            end
        end
    end

    // a new page is the free-list head, popped only now that it is used
    assign page_now = acc_new_page ? free_page : cur_page;
    assign dest_now = acc_sop ? acc_word.data[$bits(switch_pkg::port_t)-1:0] : pkt_dest;
    assign alloc    = acc_vld && acc_new_page;

    always_comb begin
        wr_req.en          = acc_vld;
        wr_req.page        = page_now;
        wr_req.offset      = acc_offset;
        wr_req.word        = acc_word;
        link_req.en        = acc_vld && acc_link;
        link_req.from_page = cur_page;
        link_req.to_page   = free_page;
        enq_req.en         = acc_vld && acc_word.eop;
        enq_req.dest       = dest_now;
        enq_req.head_page  = acc_sop ? page_now : pkt_head;
        enq_req.tail_page  = page_now;
    end

endmodule

//--- hdl/page_buffer.sv
`timescale 1ns/10ps

module page_buffer #(
    parameter int NUM_PAGES  = switch_pkg::NUM_PAGES,
    parameter int PAGE_WORDS = switch_pkg::PAGE_WORDS,
    parameter int N_PORTS    = switch_pkg::N_PORTS,
    parameter int MAX_LEN    = switch_pkg::MAX_LEN
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  switch_pkg::wr_req_t                   wr_req,
    input  switch_pkg::link_req_t                 link_req,
    input  switch_pkg::enq_req_t                  enq_req,
    input  logic                                  alloc,
    input  switch_pkg::rd_req_t                   rd_req,
    input  logic                                  page_release,
    input  logic                                  done,
    input  switch_pkg::port_t                     done_dest,
    input  switch_pkg::page_t                     done_page,
    output switch_pkg::page_t                     free_page,
    output logic                                  full,
    output logic [N_PORTS-1:0]                    queue_nonempty,
    output switch_pkg::page_t [N_PORTS-1:0]       head_page,
    output switch_pkg::buf_word_t                 rd_word,
    output switch_pkg::page_t                     rd_link
);

    localparam int PTR_W       = $clog2(NUM_PAGES);
    localparam int CNT_W       = $clog2(NUM_PAGES + 1);
    localparam int FULL_MARGIN = MAX_LEN / PAGE_WORDS + 1;

    switch_pkg::buf_word_t data_mem [NUM_PAGES*PAGE_WORDS];
    switch_pkg::page_t     link_mem [NUM_PAGES];
    switch_pkg::page_t     free_fifo [NUM_PAGES];

    logic [PTR_W-1:0]      free_rd_ptr;
    logic [PTR_W-1:0]      free_wr_ptr;
    logic [PTR_W-1:0]      init_cnt;
    logic [CNT_W-1:0]      free_cnt;
    logic                  init_busy;
    logic                  push;
    switch_pkg::page_t     push_page;

    switch_pkg::page_t     q_tail [N_PORTS];
    logic [CNT_W-1:0]      q_cnt [N_PORTS];
    logic [N_PORTS-1:0]    enq_hit;
    logic [N_PORTS-1:0]    done_hit;

    // word store and link table, read data one cycle after the request
    always_ff @(posedge clk) begin
        if (wr_req.en) begin
            data_mem[{wr_req.page, wr_req.offset}] <= wr_req.word;
        end
        if (rd_req.en) begin
            rd_word <= data_mem[{rd_req.page, rd_req.offset}];
            rd_link <= link_mem[rd_req.page];
        end
    end

    // two writers, a page inside a packet and the tail of an older packet
    always_ff @(posedge clk) begin
        if (link_req.en) begin
            link_mem[link_req.from_page] <= link_req.to_page;
        end
        if (enq_req.en && q_cnt[enq_req.dest] != '0) begin
            link_mem[q_tail[enq_req.dest]] <= enq_req.head_page;
        end
    end

    // free list, loaded with every page by a counter after reset
    assign push      = init_busy || page_release;
    assign push_page = init_busy ? switch_pkg::page_t'(init_cnt) : rd_req.page;
    assign free_page = free_fifo[free_rd_ptr];
    assign full      = init_busy || free_cnt < CNT_W'(FULL_MARGIN);

    always_ff @(posedge clk) begin
        if (push) begin
            free_fifo[free_wr_ptr] <= push_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_busy   <= 1'b1;
            init_cnt    <= '0;
            free_rd_ptr <= '0;
            free_wr_ptr <= '0;
            free_cnt    <= '0;
        end else begin
            if (init_busy) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == PTR_W'(NUM_PAGES - 1)) begin
                    init_busy <= 1'b0;
                end
            end
            if (push) begin
                free_wr_ptr <= (free_wr_ptr == PTR_W'(NUM_PAGES - 1)) ? '0 : free_wr_ptr + 1'b1;
            end
            if (alloc) begin
                free_rd_ptr <= (free_rd_ptr == PTR_W'(NUM_PAGES - 1)) ? '0 : free_rd_ptr + 1'b1;
            end
            free_cnt <= free_cnt + CNT_W'(push) - CNT_W'(alloc);
        end
    end

    always_comb begin
        for (int q = 0; q < N_PORTS; q++) begin
            enq_hit[q]        = enq_req.en && enq_req.dest == switch_pkg::port_t'(q);
            done_hit[q]       = done && done_dest == switch_pkg::port_t'(q);
            queue_nonempty[q] = q_cnt[q] != '0;
        end
    end

    // enqueue and done may hit the same queue in one cycle
    always_ff @(posedge clk) begin
        for (int q = 0; q < N_PORTS; q++) begin
            if (enq_hit[q]) begin
                q_tail[q] <= enq_req.tail_page;
            end
            if (done_hit[q]) begin
                // last packet leaving while a new one arrives
                if (enq_hit[q] && q_cnt[q] == CNT_W'(1)) begin
                    head_page[q] <= enq_req.head_page;
                end else begin
                    head_page[q] <= link_mem[done_page];
                end
            end else if (enq_hit[q] && q_cnt[q] == '0) begin
                head_page[q] <= enq_req.head_page;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < N_PORTS; q++) begin
                q_cnt[q] <= '0;
            end
        end else begin
            for (int q = 0; q < N_PORTS; q++) begin
                q_cnt[q] <= q_cnt[q] + CNT_W'(enq_hit[q]) - CNT_W'(done_hit[q]);
            end
        end
    end

endmodule

//--- hdl/packet_egress.sv
`timescale 1ns/10ps

module packet_egress #(
    parameter int N_PORTS    = switch_pkg::N_PORTS,
    parameter int PAGE_WORDS = switch_pkg::PAGE_WORDS,
    parameter int DATA_W     = switch_pkg::DATA_W
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [N_PORTS-1:0]                queue_nonempty,
    input  switch_pkg::page_t [N_PORTS-1:0]   head_page,
    input  switch_pkg::buf_word_t             rd_word,
    input  switch_pkg::page_t                 rd_link,
    input  logic [N_PORTS-1:0]                ready,
    output switch_pkg::rd_req_t               rd_req,
    output logic                              page_release,
    output logic                              done,
    output switch_pkg::port_t                 done_dest,
    output switch_pkg::page_t                 done_page,
    output logic [N_PORTS-1:0]                rd_sop,
    output logic [N_PORTS-1:0]                rd_eop,
    output logic [N_PORTS-1:0]                rd_vld,
    output logic [N_PORTS-1:0][DATA_W-1:0]    rd_data
);

    switch_pkg::egress_state_e state;
    switch_pkg::port_t         cur_q;
    switch_pkg::port_t         last_q;
    switch_pkg::port_t         sel_q;
    logic                      found;
    switch_pkg::page_t         cur_page;
    switch_pkg::offset_t       cur_off;
    logic                      first_word;
    logic                      page_end;

    // round robin, search starts after the last served queue
    always_comb begin
        switch_pkg::port_t idx;
        sel_q = last_q;
        found = 1'b0;
        for (int i = 1; i <= N_PORTS; i++) begin
            idx = switch_pkg::port_t'((int'(last_q) + i) % N_PORTS);
            if (!found && queue_nonempty[idx]) begin
                sel_q = idx;
                found = 1'b1;
            end
        end
    end

    assign page_end = cur_off == switch_pkg::offset_t'(PAGE_WORDS - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= switch_pkg::eg_pick;
            last_q <= '0;
        end else begin
            case (state)
                switch_pkg::eg_pick: begin
                    if (found) begin
                        state <= switch_pkg::eg_fetch;
                    end
                end
                switch_pkg::eg_fetch: state <= switch_pkg::eg_present;
                switch_pkg::eg_present: begin
                    if (ready[cur_q]) begin
                        state <= switch_pkg::eg_advance;
                    end
                end
                switch_pkg::eg_advance: begin
                    if (rd_word.eop) begin
                        state  <= switch_pkg::eg_pick;
                        last_q <= cur_q;
                    end else begin
                        state <= switch_pkg::eg_fetch;
                    end
                end
                default: state <= switch_pkg::eg_pick;
            endcase
        end
    end

    // page walk, follow the link at each page end
    always_ff @(posedge clk) begin
        case (state)
            switch_pkg::eg_pick: begin
                if (found) begin
                    cur_q      <= sel_q;
                    cur_page   <= head_page[sel_q];
                    cur_off    <= '0;
                    first_word <= 1'b1;
                end
            end
            switch_pkg::eg_advance: begin
                first_word <= 1'b0;
                if (page_end) begin
                    cur_page <= rd_link;
                    cur_off  <= '0;
                end else begin
                    cur_off <= cur_off + 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        rd_req.en     = state == switch_pkg::eg_fetch;
        rd_req.page   = cur_page;
        rd_req.offset = cur_off;
        // page is done after its last slot or the packet end
        page_release  = state == switch_pkg::eg_advance && (page_end || rd_word.eop);
        done          = state == switch_pkg::eg_advance && rd_word.eop;
        done_dest     = cur_q;
        done_page     = cur_page;
    end

    always_comb begin
        for (int i = 0; i < N_PORTS; i++) begin
            rd_vld[i]  = state == switch_pkg::eg_present && cur_q == switch_pkg::port_t'(i);
            rd_sop[i]  = rd_vld[i] && first_word;
            rd_eop[i]  = rd_vld[i] && rd_word.eop;
            rd_data[i] = rd_word.data;
        end
    end

endmodule

//--- hdl/shared_buffer_switch.sv
`timescale 1ns/10ps

module shared_buffer_switch #(
    parameter int DATA_W     = switch_pkg::DATA_W,
    parameter int PAGE_WORDS = switch_pkg::PAGE_WORDS,
    parameter int NUM_PAGES  = switch_pkg::NUM_PAGES,
    parameter int N_PORTS    = switch_pkg::N_PORTS,
    parameter int MAX_LEN    = switch_pkg::MAX_LEN
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_sop,
    input  logic                           wr_eop,
    input  logic                           wr_vld,
    input  logic [DATA_W-1:0]              wr_data,
    output logic                           full,
    input  logic [N_PORTS-1:0]             ready,
    output logic [N_PORTS-1:0]             rd_sop,
    output logic [N_PORTS-1:0]             rd_eop,
    output logic [N_PORTS-1:0]             rd_vld,
    output logic [N_PORTS-1:0][DATA_W-1:0] rd_data
);

    switch_pkg::wr_req_t                wr_req;
    switch_pkg::link_req_t              link_req;
    switch_pkg::enq_req_t               enq_req;
    logic                               alloc;
    switch_pkg::page_t                  free_page;
    switch_pkg::rd_req_t                rd_req;
    logic                               page_release;
    logic                               done;
    switch_pkg::port_t                  done_dest;
    switch_pkg::page_t                  done_page;
    logic [N_PORTS-1:0]                 queue_nonempty;
    switch_pkg::page_t [N_PORTS-1:0]    head_page;
    switch_pkg::buf_word_t              rd_word;
    switch_pkg::page_t                  rd_link;

    packet_ingress #(
        .DATA_W     (DATA_W),
        .PAGE_WORDS (PAGE_WORDS)
    ) u_ingress (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_sop    (wr_sop),
        .wr_eop    (wr_eop),
        .wr_vld    (wr_vld),
        .wr_data   (wr_data),
        .free_page (free_page),
        .full      (full),
        .wr_req    (wr_req),
        .link_req  (link_req),
        .enq_req   (enq_req),
        .alloc     (alloc)
    );

    page_buffer #(
        .NUM_PAGES  (NUM_PAGES),
        .PAGE_WORDS (PAGE_WORDS),
        .N_PORTS    (N_PORTS),
        .MAX_LEN    (MAX_LEN)
    ) u_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_req         (wr_req),
        .link_req       (link_req),
        .enq_req        (enq_req),
        .alloc          (alloc),
        .rd_req         (rd_req),
        .page_release   (page_release),
        .done           (done),
        .done_dest      (done_dest),
        .done_page      (done_page),
        .free_page      (free_page),
        .full           (full),
        .queue_nonempty (queue_nonempty),
        .head_page      (head_page),
        .rd_word        (rd_word),
        .rd_link        (rd_link)
    );

    packet_egress #(
        .N_PORTS    (N_PORTS),
        .PAGE_WORDS (PAGE_WORDS),
        .DATA_W     (DATA_W)
    ) u_egress (
        .clk            (clk),
        .rst_n          (rst_n),
        .queue_nonempty (queue_nonempty),
        .head_page      (head_page),
        .rd_word        (rd_word),
        .rd_link        (rd_link),
        .ready          (ready),
        .rd_req         (rd_req),
        .page_release   (page_release),
        .done           (done),
        .done_dest      (done_dest),
        .done_page      (done_page),
        .rd_sop         (rd_sop),
        .rd_eop         (rd_eop),
        .rd_vld         (rd_vld),
        .rd_data        (rd_data)
    );

endmodule

//--- test/tb_switch_tasks.svh
`ifndef TB_SWITCH_TASKS_SVH
`define TB_SWITCH_TASKS_SVH

// one check, a mismatch is counted and printed right away
task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
endtask

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int p = 0; p < N_PORTS; p++) begin
        if (exp_rd[p] != exp_wr[p]) begin
            empty = 1'b0;
        end
    end
    return empty;
endfunction

// returns on the edge where the next word may be driven
task automatic wait_not_full(input int limit, output bit ok);
    int n;
    n = 0;
    ok = 1'b1;
    do begin
        @(posedge clk);
        n++;
    end while (full !== 1'b0 && n < limit);
    if (full !== 1'b0) begin
        $display("timeout at %0t: full stayed high for %0d cycles", $time, limit);
        errors++;
        ok = 1'b0;
    end
endtask

task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (!queues_empty() && n < limit) begin
        @(posedge clk);
        n++;
    end
    if (!queues_empty()) begin
        $display("timeout at %0t: expected words still missing after %0d cycles", $time, limit);
        errors++;
    end
endtask

task automatic wait_full_low(input int limit);
    int n;
    n = 0;
    while (full !== 1'b0 && n < limit) begin
        @(posedge clk);
        n++;
    end
    if (full !== 1'b0) begin
        $display("timeout at %0t: full did not fall within %0d cycles", $time, limit);
        errors++;
    end
endtask

`endif

//--- test/tb_switch.sv
`timescale 1ns/10ps

module tb_switch;

    localparam int DATA_W     = switch_pkg::DATA_W;
    localparam int PAGE_WORDS = switch_pkg::PAGE_WORDS;
    localparam int NUM_PAGES  = switch_pkg::NUM_PAGES;
    localparam int N_PORTS    = switch_pkg::N_PORTS;
    localparam int MAX_LEN    = switch_pkg::MAX_LEN;
    localparam int PORT_W     = $clog2(N_PORTS);
    localparam int EXP_DEPTH  = 1024;
    localparam int MAX_ROWS   = 64;
    localparam int SOAK_TEST  = 6;
    localparam int WAIT_LIMIT = 200000;

    logic                           clk;
    logic                           rst_n;
    logic                           wr_sop;
    logic                           wr_eop;
    logic                           wr_vld;
    logic [DATA_W-1:0]              wr_data;
    logic                           full;
    logic [N_PORTS-1:0]             ready;
    logic [N_PORTS-1:0]             rd_sop;
    logic [N_PORTS-1:0]             rd_eop;
    logic [N_PORTS-1:0]             rd_vld;
    logic [N_PORTS-1:0][DATA_W-1:0] rd_data;

    // four hex fields per row: test, destination, length, stall mode
    logic [15:0]       pkt_tab [0:4*MAX_ROWS-1];
    // expected words per port as {sop, eop, data}
    logic [DATA_W+1:0] exp_mem [0:N_PORTS-1][0:EXP_DEPTH-1];
    int                exp_wr  [0:N_PORTS-1];
    int                exp_rd  [0:N_PORTS-1];
    int                errors;
    int                checks;
    int                tests;
    int                stall_mode;
    bit                ready_hold;
    logic [31:0]       pay_rnd;
    logic [31:0]       rdy_rnd;

    `include "tb_switch_tasks.svh"

    shared_buffer_switch #(
        .DATA_W     (DATA_W),
        .PAGE_WORDS (PAGE_WORDS),
        .NUM_PAGES  (NUM_PAGES),
        .N_PORTS    (N_PORTS),
        .MAX_LEN    (MAX_LEN)
    ) DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    always #5 clk = ~clk;

    // ready per stall mode, mode 2 holds it low until the fill is over
    always @(posedge clk) begin
        if (stall_mode == 1) begin
            rdy_rnd = xorshift(rdy_rnd);
            ready <= rdy_rnd[N_PORTS-1:0];
        end else if (stall_mode == 2 && ready_hold) begin
            ready <= '0;
        end else begin
            ready <= '1;
        end
    end

    function automatic int pages_of(input int len);
        return (len + PAGE_WORDS - 1) / PAGE_WORDS;
    endfunction

    task automatic take_word(input int p);
        logic [DATA_W+1:0] exp;
        if (exp_rd[p] == exp_wr[p]) begin
            $display("error at %0t: port %0d sent a word that was never sent in", $time, p);
            errors++;
        end else begin
            exp = exp_mem[p][exp_rd[p] % EXP_DEPTH];
            exp_rd[p]++;
            compare($sformatf("rd_sop[%0d]", p), rd_sop[p], exp[DATA_W+1]);
            compare($sformatf("rd_eop[%0d]", p), rd_eop[p], exp[DATA_W]);
            compare($sformatf("rd_data[%0d]", p), rd_data[p], exp[DATA_W-1:0]);
        end
    endtask

    task automatic sample_ports();
        int p;
        for (p = 0; p < N_PORTS; p++) begin
            if (rd_vld[p] === 1'b1 && ready[p] === 1'b1) begin
                take_word(p);
            end
        end
    endtask

    // a word moves on the next rising edge, seen stable here
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            sample_ports();
        end
    end

    task automatic send_packet(input int dest, input int len);
        logic [DATA_W-1:0] data;
        bit                ok;
        int                w;
        wait_not_full(WAIT_LIMIT, ok);
        if (ok) begin
            for (w = 0; w < len; w++) begin
                pay_rnd = xorshift(pay_rnd);
                data = pay_rnd[DATA_W-1:0];
                // header carries the destination in its low bits
                if (w == 0) begin
                    data[PORT_W-1:0] = dest[PORT_W-1:0];
                end
                exp_mem[dest][exp_wr[dest] % EXP_DEPTH] = {w == 0, w == len - 1, data};
                exp_wr[dest]++;
                wr_vld  <= 1'b1;
                wr_sop  <= w == 0;
                wr_eop  <= w == len - 1;
                wr_data <= data;
                @(posedge clk);
            end
            wr_vld <= 1'b0;
            wr_sop <= 1'b0;
            wr_eop <= 1'b0;
            // let the last page pop reach the free count before the next sop
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic check_reset_release();
        int n;
        int base;
        base = errors;
        n = 0;
        while (full !== 1'b0 && n < NUM_PAGES + 10) begin
            @(posedge clk);
            compare("rd_vld", rd_vld, '0);
            n++;
        end
        if (full !== 1'b0) begin
            $display("error at %0t: full still high %0d cycles after reset", $time, n);
            errors++;
        end
        repeat (10) begin
            @(posedge clk);
            compare("rd_vld", rd_vld, '0);
        end
        tests++;
        $display("test 1: full fell after %0d cycles, %0d errors", n, errors - base);
    endtask

    task automatic run_test(input int test_no, input int first, input int last);
        int base;
        int pages;
        int packets;
        int r;
        bit full_seen;
        base = errors;
        pages = 0;
        packets = 0;
        full_seen = 1'b0;
        stall_mode = pkt_tab[first*4+3];
        ready_hold = stall_mode == 2;
        if (stall_mode == 2) begin
            // replay the rows until the buffer pushes back
            while (!full_seen && pages <= 2 * NUM_PAGES) begin
                for (r = first; r < last && !full_seen; r++) begin
                    if (full === 1'b1) begin
                        full_seen = 1'b1;
                    end else begin
                        send_packet(pkt_tab[r*4+1], pkt_tab[r*4+2]);
                        pages += pages_of(pkt_tab[r*4+2]);
                        packets++;
                    end
                end
            end
            if (!full_seen) begin
                $display("error at %0t: full never rose after %0d pages", $time, pages);
                errors++;
            end
            compare("pages_before_full", pages <= NUM_PAGES, 1);
            ready_hold = 1'b0;
        end else begin
            do begin
                for (r = first; r < last; r++) begin
                    send_packet(pkt_tab[r*4+1], pkt_tab[r*4+2]);
                    pages += pages_of(pkt_tab[r*4+2]);
                    packets++;
                end
            end while (test_no == SOAK_TEST && pages <= 3 * NUM_PAGES);
        end
        wait_drained(WAIT_LIMIT);
        repeat (4) @(posedge clk);
        wait_full_low(WAIT_LIMIT);
        tests++;
        $display("test %0d: %0d packets, %0d pages, %0d errors",
                 test_no, packets, pages, errors - base);
    endtask

    initial begin
        int row;
        int last;
        int test_no;
        clk        = 1'b0;
        rst_n      = 1'b0;
        wr_sop     = 1'b0;
        wr_eop     = 1'b0;
        wr_vld     = 1'b0;
        wr_data    = '0;
        ready      = '0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        stall_mode = 0;
        ready_hold = 1'b0;
        pay_rnd    = 32'h4461;
        rdy_rnd    = 32'h4461;
        for (row = 0; row < N_PORTS; row++) begin
            exp_wr[row] = 0;
            exp_rd[row] = 0;
        end
        for (row = 0; row < 4 * MAX_ROWS; row++) begin
            pkt_tab[row] = '0;
        end
        $readmemh("test/switch_input.txt", pkt_tab);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_release();

        // rows of one test are contiguous, test number 0 ends the table
        row = 0;
        while (row < MAX_ROWS && pkt_tab[row*4] != 0) begin
            test_no = pkt_tab[row*4];
            last = row;
            while (last < MAX_ROWS && pkt_tab[last*4] == test_no) begin
                last++;
            end
            run_test(test_no, row, last);
            row = last;
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- test/switch_input.txt
// columns in hex: test, destination, length in words, ready stall mode
// stall mode 0 ready high, 1 random ready, 2 ready low until full
2 0 01 0
2 1 08 0
2 2 09 0
2 3 20 0
2 1 0f 0
3 2 05 0
3 2 10 0
3 2 03 0
3 2 11 0
3 2 20 0
3 2 01 0
4 0 07 1
4 1 20 1
4 2 0c 1
4 3 01 1
4 0 19 1
4 3 12 1
4 1 09 1
4 2 1f 1
5 0 20 2
5 1 20 2
5 2 20 2
5 3 20 2
6 0 20 1
6 1 11 1
6 2 08 1
6 3 1d 1
6 1 02 1
6 0 20 1

//--- filelist.f
+incdir+test
hdl/switch_pkg.sv
hdl/packet_ingress.sv
hdl/page_buffer.sv
hdl/packet_egress.sv
hdl/shared_buffer_switch.sv
test/tb_switch.sv
